// ==== nnPkg.sv ====
package nnPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int ACT_W = 8;
	localparam int ACC_W = 20; // 15 full-scale products plus bias, no wrap
	localparam int SCORE_W = ACC_W - 1; // relu result, sign bit dropped
	localparam int CLASS_W = 2;

	typedef logic signed [ACT_W-1:0] actT;
	typedef logic signed [ACC_W-1:0] accT;
	typedef logic [SCORE_W-1:0] scoreT;
	typedef logic [CLASS_W-1:0] classT;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// network shape
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int N_FEAT = 15; // input features
	localparam int N_HID = 4; // hidden neurons
	localparam int N_OUT = 3; // classes

	// hidden score back to 8 bits
	localparam int ACT_SHIFT = 7;
	localparam int ACT_MAX = 127;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// hidden layer weights and biases
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// row per neuron, column per feature
	localparam actT HID_W [N_HID][N_FEAT] = '{
		// neuron 0
		'{
			117, -4, 74, -14, 16,
			-43, 104, 5, -1, 48,
			108, 25, -6, -13, -5
		},
		// neuron 1
		'{
			-22, 63, -7, 90, -51,
			14, -33, 76, 8, -69,
			41, -12, 57, 29, -84
		},
		// neuron 2
		'{
			38, -95, 21, 6, 72,
			-18, -60, 11, 99, -27,
			-3, 66, -44, 85, 17
		},
		// neuron 3
		'{
			-71, 9, 52, -36, -88,
			47, 25, -15, 64, 3,
			-58, -79, 31, -10, 46
		}
	};

	localparam actT HID_B [N_HID] = '{
		11, // neuron 0
		-7,
		4,
		20
	};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output layer weights and biases
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// row per class, column per hidden activation
	localparam actT OUT_W [N_OUT][N_HID] = '{
		'{ 23, -41, 67, 12 }, // class 0
		'{ -35, 58, -9, 44 }, // class 1
		'{ 51, 17, -62, -28 } // class 2
	};

	localparam actT OUT_B [N_OUT] = '{
		5,
		-3,
		9
	};

endpackage

// ==== neuronNode.sv ====
`timescale 1ns/1ps

module neuronNode
	import nnPkg::*;
#(
	parameter int FAN_IN = N_FEAT,
	parameter int ROW = 0,
	parameter bit OUTPUT_LAYER = 1'b0
)
(
	input logic clk,
	input logic reset,
	input actT act [FAN_IN],
	output scoreT score
);

	actT weight [FAN_IN]; // constant row from the tables
	actT bias;
	actT actReg [FAN_IN];
	accT prod [FAN_IN];
	accT sumNext;
	accT sumReg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// table row selection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	generate
		if (OUTPUT_LAYER)
		begin : gOutTab
			for (genvar i = 0; i < FAN_IN; i++)
			begin : gW
				assign weight[i] = OUT_W[ROW][i];
			end
			assign bias = OUT_B[ROW];
		end
		else
		begin : gHidTab
			for (genvar i = 0; i < FAN_IN; i++)
			begin : gW
				assign weight[i] = HID_W[ROW][i];
			end
			assign bias = HID_B[ROW];
		end
	endgenerate

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// products and sum
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// extend before multiply so the product is not cut to 8 bits
	always_comb
	begin
		for (int i = 0; i < FAN_IN; i++)
		begin
			prod[i] = accT'(actReg[i]) * accT'(weight[i]);
		end
	end

	always_comb
	begin
		sumNext = accT'(bias);
		for (int i = 0; i < FAN_IN; i++)
		begin
			sumNext = sumNext + prod[i];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// three register stages
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '{default: '0};
			sumReg <= '0;
			score <= '0;
		end
		else
		begin
			actReg <= act; // stage 1
			sumReg <= sumNext; // stage 2
			// stage 3, relu on the true sign bit
			if (sumReg[ACC_W-1])
			begin
				score <= '0;
			end
			else
			begin
				score <= scoreT'(sumReg[SCORE_W-1:0]);
			end
		end
	end

endmodule

// ==== denseLayer.sv ====
`timescale 1ns/1ps

module denseLayer
	import nnPkg::*;
#(
	parameter int FAN_IN = N_FEAT,
	parameter int N_NODE = N_HID,
	parameter bit OUTPUT_LAYER = 1'b0
)
(
	input logic clk,
	input logic reset,
	input actT act [FAN_IN],
	output scoreT score [N_NODE],
	output actT actOut [N_NODE]
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// one neuron per table row
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	generate
		for (genvar n = 0; n < N_NODE; n++)
		begin : gNode
			neuronNode #(
				.FAN_IN(FAN_IN),
				.ROW(n),
				.OUTPUT_LAYER(OUTPUT_LAYER)
			) i_node (
				.clk(clk),
				.reset(reset),
				.act(act),
				.score(score[n])
			);
		end
	endgenerate

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// requantization
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// score is never negative after relu, so only the top clip is needed
	generate
		for (genvar n = 0; n < N_NODE; n++)
		begin : gQuant
			scoreT shifted;

			assign shifted = score[n] >> ACT_SHIFT;

			always_comb
			begin
				if (shifted > scoreT'(ACT_MAX))
				begin
					actOut[n] = actT'(ACT_MAX); // clip
				end
				else
				begin
					actOut[n] = actT'(shifted[ACT_W-1:0]);
				end
			end
		end
	endgenerate

endmodule

// ==== argmaxSelect.sv ====
`timescale 1ns/1ps

module argmaxSelect
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input scoreT score [N_OUT],
	output classT classId,
	output scoreT classScore
);

	classT bestId;
	scoreT bestScore;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare in index order
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// strict compare keeps the lowest index on a tie
	always_comb
	begin
		bestId = '0;
		bestScore = score[0];
		for (int i = 1; i < N_OUT; i++)
		begin
			if (score[i] > bestScore)
			begin
				bestId = classT'(i);
				bestScore = score[i];
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// result register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classId <= '0;
			classScore <= '0;
		end
		else
		begin
			classId <= bestId;
			classScore <= bestScore; // score of the winner
		end
	end

endmodule

// ==== mlpClassifier.sv ====
`timescale 1ns/1ps

module mlpClassifier
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input actT feature [N_FEAT],
	output scoreT outScore [N_OUT],
	output classT classId,
	output scoreT classScore
);

	actT hidAct [N_HID]; // requantized hidden outputs

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// hidden layer, 3 cycles
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	denseLayer #(
		.FAN_IN(N_FEAT),
		.N_NODE(N_HID),
		.OUTPUT_LAYER(1'b0)
	) i_hidLayer (
		.clk(clk),
		.reset(reset),
		.act(feature),
		.score(),
		.actOut(hidAct)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output layer, 3 cycles
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	denseLayer #(
		.FAN_IN(N_HID),
		.N_NODE(N_OUT),
		.OUTPUT_LAYER(1'b1)
	) i_outLayer (
		.clk(clk),
		.reset(reset),
		.act(hidAct),
		.score(outScore),
		.actOut() // raw scores go to argmax
	);

	// winner pick, 1 cycle
	argmaxSelect i_argmax (
		.clk(clk),
		.reset(reset),
		.score(outScore),
		.classId(classId),
		.classScore(classScore)
	);

endmodule

// ==== mlpClassifier_properties.sv ====
`timescale 1ns/1ps

module mlpClassifier_properties
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input scoreT outScore [N_OUT],
	input classT classId,
	input scoreT classScore
);

	int failCount = 0;
	scoreT prevScore [N_OUT]; // argmax input one cycle back

	always @(posedge clk)
	begin
		prevScore <= outScore;
	end

	clearAfterReset: assert property (@(posedge clk)
		reset |=> (classId == '0 && classScore == '0))
	else
	begin
		failCount++;
		$error("classId or classScore not cleared one cycle after reset");
	end

	classInRange: assert property (@(posedge clk) disable iff (reset)
		classId < N_OUT)
	else
	begin
		failCount++;
		$error("classId out of range");
	end

	// winner score is the selected entry of last cycle's scores
	scoreMatchesClass: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> classScore == prevScore[classId])
	else
	begin
		failCount++;
		$error("classScore differs from the score of the selected class");
	end

endmodule

// ==== mlpChecker.sv ====
`timescale 1ns/1ps

module mlpChecker
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input actT feature [N_FEAT],
	input scoreT outScore [N_OUT],
	input classT classId,
	input scoreT classScore,
	input logic testEnd,
	input int testNum,
	output int errCount,
	output int checkCount
);

	localparam int SCORE_LAT = 6; // edges from sample to outScore check
	localparam int CLASS_LAT = 7;

	scoreT pipeScore [CLASS_LAT][N_OUT];
	classT pipeId [CLASS_LAT];
	scoreT pipeBest [CLASS_LAT];
	int liveCount = 0; // edges since reset release
	logic prevReset = 1'b0;
	int testErr = 0;
	int testChk = 0;

	initial
	begin
		errCount = 0;
		checkCount = 0;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference network
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic void runModel(input actT f [N_FEAT], output scoreT sc [N_OUT],
		output classT id, output scoreT best);
		int acc;
		int hid [N_HID];

		for (int n = 0; n < N_HID; n++)
		begin
			acc = int'(HID_B[n]);
			for (int i = 0; i < N_FEAT; i++)
			begin
				acc += int'(f[i]) * int'(HID_W[n][i]);
			end
			acc = (acc < 0) ? 0 : acc / (1 << ACT_SHIFT); // relu, then requantize
			hid[n] = (acc > ACT_MAX) ? ACT_MAX : acc;
		end
		for (int c = 0; c < N_OUT; c++)
		begin
			acc = int'(OUT_B[c]);
			for (int j = 0; j < N_HID; j++)
			begin
				acc += hid[j] * int'(OUT_W[c][j]);
			end
			sc[c] = (acc < 0) ? '0 : scoreT'(acc);
		end
		id = '0;
		best = sc[0];
		for (int c = 1; c < N_OUT; c++)
		begin
			if (sc[c] > best) // ties keep lowest index
			begin
				id = classT'(c);
				best = sc[c];
			end
		end
	endfunction

	function automatic string testLabel(input int num);
		case (num)
			1: return "reset";
			2: return "zeros";
			3: return "saturate";
			4: return "ties";
			default: return "stream";
		endcase
	endfunction

	task automatic compareValue(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		checkCount++;
		testChk++;
		if (actVal !== expVal)
		begin
			errCount++;
			testErr++;
			$display("FAILED %s expected %h actual %h", name, expVal, actVal);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// delay line and compare
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk)
	begin
		scoreT expScore [N_OUT];
		classT expId;
		scoreT expBest;

		runModel(feature, expScore, expId, expBest);
		if (prevReset)
		begin
			for (int c = 0; c < N_OUT; c++)
			begin
				compareValue($sformatf("outScore[%0d]", c), 32'd0, 32'(outScore[c]));
			end
			compareValue("classId", 32'd0, 32'(classId));
			compareValue("classScore", 32'd0, 32'(classScore));
		end
		else
		begin
			if (liveCount >= SCORE_LAT)
			begin
				for (int c = 0; c < N_OUT; c++)
				begin
					compareValue($sformatf("outScore[%0d]", c),
						32'(pipeScore[SCORE_LAT-1][c]), 32'(outScore[c]));
				end
			end
			if (liveCount >= CLASS_LAT)
			begin
				compareValue("classId", 32'(pipeId[CLASS_LAT-1]), 32'(classId));
				compareValue("classScore", 32'(pipeBest[CLASS_LAT-1]), 32'(classScore));
			end
		end

		for (int k = CLASS_LAT - 1; k > 0; k--)
		begin
			pipeScore[k] = pipeScore[k-1];
			pipeId[k] = pipeId[k-1];
			pipeBest[k] = pipeBest[k-1];
		end
		pipeScore[0] = expScore;
		pipeId[0] = expId;
		pipeBest[0] = expBest;

		if (reset)
		begin
			liveCount = 0;
		end
		else if (liveCount < CLASS_LAT)
		begin
			liveCount++;
		end
		prevReset = reset;

		if (testEnd)
		begin
			$display("test %0d %s: %0d checks, %0d errors", testNum, testLabel(testNum),
				testChk, testErr);
			testChk = 0;
			testErr = 0;
		end
	end

endmodule

// ==== mlpClassifierTb.sv ====
`timescale 1ns/1ps

module mlpClassifierTb
	import nnPkg::*;
();

	localparam int RESET_CYCLES = 10;
	localparam logic [31:0] LFSR_SEED = 32'd98845;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;
	// 356 vectors, 5 tests, 2 resets
	localparam int TIMEOUT = 356 + 8 * 5 + RESET_CYCLES * 2 + 50;

	logic clk = 1'b0;
	logic reset;
	actT feature [N_FEAT];
	scoreT outScore [N_OUT];
	classT classId;
	scoreT classScore;
	logic testEnd;
	int testNum;
	int errCount;
	int checkCount;
	int cycleCount = 0;
	logic [31:0] lfsrState = LFSR_SEED;

	always #2 clk = ~clk;

	mlpClassifier i_mlpClassifier (
		.clk(clk),
		.reset(reset),
		.feature(feature),
		.outScore(outScore),
		.classId(classId),
		.classScore(classScore)
	);

	mlpChecker i_checker (
		.clk(clk),
		.reset(reset),
		.feature(feature),
		.outScore(outScore),
		.classId(classId),
		.classScore(classScore),
		.testEnd(testEnd),
		.testNum(testNum),
		.errCount(errCount),
		.checkCount(checkCount)
	);

	bind mlpClassifier mlpClassifier_properties i_props (.*);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic stepLfsr();
		logic outBit;

		outBit = lfsrState[0];
		lfsrState = (lfsrState >> 1) ^ (outBit ? LFSR_TAPS : 32'd0);
		return outBit;
	endfunction

	function automatic actT randomByte();
		actT b;

		b = '0;
		for (int k = 0; k < 8; k++)
		begin
			b = {b[6:0], stepLfsr()};
		end
		return b;
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic holdReset();
		reset = 1'b1;
		repeat (RESET_CYCLES) nextCycle();
		reset = 1'b0;
	endtask

	task automatic sendRandom(input int count);
		for (int v = 0; v < count; v++)
		begin
			for (int i = 0; i < N_FEAT; i++)
			begin
				feature[i] = randomByte();
			end
			nextCycle();
		end
	endtask

	task automatic sendFill(input actT value, input int count);
		feature = '{default: value};
		repeat (count) nextCycle();
	endtask

	// full scale with or against neuron n's weight signs
	task automatic sendSigned(input int n, input bit oppose);
		for (int i = 0; i < N_FEAT; i++)
		begin
			feature[i] = ((HID_W[n][i] >= 0) != oppose) ? actT'(127) : actT'(-128);
		end
		nextCycle();
	endtask

	// hidden activations 92, 0, 20, 0 put classes 0 and 2 level at 3461
	task automatic sendTie();
		feature = '{default: '0};
		feature[0] = actT'(100);
		feature[1] = actT'(12);
		feature[10] = actT'(2);
		nextCycle();
	endtask

	task automatic endTest(input int num);
		repeat (7) nextCycle(); // drain the pipeline
		testNum = num;
		testEnd = 1'b1;
		nextCycle();
		testEnd = 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		testEnd = 1'b0;
		testNum = 0;
		feature = '{default: '0};
		holdReset();
		sendRandom(20);
		holdReset(); // flush mid stream
		sendRandom(20);
		endTest(1);
		sendFill('0, 5);
		endTest(2);
		sendFill(actT'(127), 1);
		sendFill(actT'(-128), 1);
		for (int n = 0; n < N_HID; n++)
		begin
			sendSigned(n, 1'b0);
			sendSigned(n, 1'b1);
		end
		endTest(3);
		sendTie(); // class 0 wins the tie with class 2
		endTest(4);
		sendRandom(300);
		endTest(5);

		$display("%0d checks, %0d errors, %0d assertion failures", checkCount, errCount,
			i_mlpClassifier.i_props.failCount);
		if (errCount == 0 && i_mlpClassifier.i_props.failCount == 0 && checkCount > 0)
		begin
			$display("NO ERRORS");
		end
		else
		begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= TIMEOUT)
		begin
			$display("run timed out after %0d cycles", cycleCount);
			$display("ERRORS FOUND");
			$finish;
		end
	end

endmodule

// ==== mlpClassifier.f ====
nnPkg.sv
neuronNode.sv
denseLayer.sv
argmaxSelect.sv
mlpClassifier.sv
mlpClassifier_properties.sv
mlpChecker.sv
mlpClassifierTb.sv
